//--- Bender.yml
package:
  name: rafi_front_end

sources:
  # Package and interfaces ahead of the blocks that import them
  - include_dirs:
      - common
    files:
      - common/rafiFetchPkg.sv
      - common/fetchIfs.sv
      - fetch/FetchUnit.sv
      - fetch/FetchStage.sv
      - fetch/InsnBuffer.sv
      - design/InsnAligner.sv
      - design/FrontEnd.sv

  # Testbench top tbFrontEnd
  - target: test
    include_dirs:
      - common
      - tb
    files:
      - tb/tbFrontEnd.sv

//--- common/fetchIfs.sv
// Interfaces linking fetch unit, fetch stage, halfword buffer and aligner
`timescale 1ns/1ps

// ~~~~~~~~~~~~~~~~~~~~
// Fetch unit to stage
// ~~~~~~~~~~~~~~~~~~~~
interface FetchUnitIF import rafiFetchPkg::*; ();
    vaddr_t pc;  // Current fetch PC
    line_t iLine;  // Line at PC
    logic valid;  // Line is meaningful
    faultKind_e fault;  // Fault of this fetch
    vaddr_t nextPc;  // Redirect target
    logic flush;  // Redirect strobe
    logic stall;  // Hold PC, line not taken

    modport FetchUnit(output pc, iLine, valid, fault, input nextPc, flush, stall);
    modport FetchStage(input pc, iLine, valid, fault, output nextPc, flush, stall);
endinterface

// ~~~~~~~~~~~~~~~~~~~~
// Stage to buffer
// ~~~~~~~~~~~~~~~~~~~~
interface InsnBufferIF import rafiFetchPkg::*; ();
    logic writeLow;  // Low half written, first in order
    logic writeHigh;  // High half written
    ibufEntry_t writeEntryLow;
    ibufEntry_t writeEntryHigh;
    ibufCount_t writableEntryCount;  // Free slots

    modport FetchStage(output writeLow, writeHigh, writeEntryLow, writeEntryHigh,
                       input writableEntryCount);
    modport InsnBuffer(input writeLow, writeHigh, writeEntryLow, writeEntryHigh,
                       output writableEntryCount);
endinterface

// ~~~~~~~~~~~~~~~~~~~~
// Buffer to aligner
// ~~~~~~~~~~~~~~~~~~~~
interface AlignIF import rafiFetchPkg::*; ();
    ibufEntry_t headEntry;  // Oldest entry
    ibufEntry_t nextEntry;  // Second oldest
    ibufCount_t validCount;  // Occupied slots
    logic pop1;  // Drop one entry
    logic pop2;  // Drop two entries

    modport InsnBuffer(output headEntry, nextEntry, validCount, input pop1, pop2);
    modport InsnAligner(input headEntry, nextEntry, validCount, output pop1, pop2);
endinterface

//--- common/rafiFetchPkg.sv
// Shared front end types, imported by every block between memory and the decoder
package rafiFetchPkg;

`include "rafi_config.svh"

    // ~~~~~~~~~~~~~~~~~~~~
    // Basic words
    // ~~~~~~~~~~~~~~~~~~~~

    typedef logic [31:0] vaddr_t;  // Virtual address
    typedef logic [31:0] insn_t;  // Full instruction word
    typedef logic [15:0] half_t;  // One parcel
    typedef logic [`RAFI_LINE_WIDTH-1:0] line_t;  // One memory line
    typedef logic [3:0] intCode_t;  // Interrupt cause

    // Free or used slot count, holds 0 to depth
    typedef logic [$clog2(`RAFI_IBUF_DEPTH):0] ibufCount_t;

    // ~~~~~~~~~~~~~~~~~~~~
    // Faults and entries
    // ~~~~~~~~~~~~~~~~~~~~

    typedef enum logic {
        NONE,  // Clean fetch
        OUT_OF_RANGE  // PC beyond memory
    } faultKind_e;

    // One halfword with its tags, 54 bits
    typedef struct packed {
        vaddr_t pc;  // PC of this halfword
        half_t half;  // Raw parcel
        faultKind_e fault;  // Fetch fault
        logic interruptValid;  // Interrupt pending at fetch
        intCode_t interruptCode;  // Its cause
    } ibufEntry_t;

endpackage

//--- common/rafi_config.svh
// Size macros for the instruction front end, included by the package and the sizing modules

`ifndef RAFI_CONFIG_SVH
`define RAFI_CONFIG_SVH

// ~~~~~~~~~~~~~~~~~~~~
// Instruction memory
// ~~~~~~~~~~~~~~~~~~~~

`define RAFI_LINE_WIDTH 64  // Bits per memory line

`define RAFI_IMEM_LINES 16  // Lines in memory, bytes 0 to 127

// ~~~~~~~~~~~~~~~~~~~~
// Halfword buffer
// ~~~~~~~~~~~~~~~~~~~~

`define RAFI_IBUF_DEPTH 8  // Halfword entries, power of two

`endif

//--- compile.f
+incdir+common
+incdir+tb
common/rafiFetchPkg.sv
common/fetchIfs.sv
fetch/FetchUnit.sv
fetch/FetchStage.sv
fetch/InsnBuffer.sv
design/InsnAligner.sv
design/FrontEnd.sv
tb/tbFrontEnd.sv

//--- design/FrontEnd.sv
// Front end top, memory fetch through halfword buffer to aligned instructions for decode
`timescale 1ns/1ps

module FrontEnd import rafiFetchPkg::*; (
    input  logic clk,
    input  logic arstN,
    input  logic memWe,  // Program load
    input  logic [3:0] memLineIdx,
    input  line_t memLine,
    input  logic redirect,  // Flush to redirectPc
    input  vaddr_t redirectPc,
    input  logic ifStall,
    input  logic interruptValid,
    input  intCode_t interruptCode,
    input  logic insnReady,
    output logic insnValid,
    output vaddr_t insnPc,
    output insn_t insn,
    output logic insnCompressed,
    output faultKind_e insnFault,
    output logic insnInterruptValid,
    output intCode_t insnInterruptCode
);
    FetchUnitIF fetchUnitIf();
    InsnBufferIF insnBufferIf();
    AlignIF alignIf();

    // ~~~~~~~~~~~~~~~~~~~~
    // Fetch path
    // ~~~~~~~~~~~~~~~~~~~~

    FetchUnit u_FetchUnit (
        .clk        (clk),
        .arstN      (arstN),
        .memWe      (memWe),
        .memLineIdx (memLineIdx),
        .memLine    (memLine),
        .fetchUnit  (fetchUnitIf.FetchUnit)
    );

    FetchStage u_FetchStage (
        .clk            (clk),
        .arstN          (arstN),
        .fetchUnit      (fetchUnitIf.FetchStage),
        .insnBuffer     (insnBufferIf.FetchStage),
        .redirect       (redirect),
        .redirectPc     (redirectPc),
        .ifStall        (ifStall),
        .interruptValid (interruptValid),
        .interruptCode  (interruptCode)
    );

    // ~~~~~~~~~~~~~~~~~~~~
    // Buffer and decode
    // ~~~~~~~~~~~~~~~~~~~~

    InsnBuffer u_InsnBuffer (
        .clk        (clk),
        .arstN      (arstN),
        .flush      (redirect),  // Same edge as PC load
        .insnBuffer (insnBufferIf.InsnBuffer),
        .align      (alignIf.InsnBuffer)
    );

    InsnAligner u_InsnAligner (
        .clk                (clk),
        .arstN              (arstN),
        .align              (alignIf.InsnAligner),
        .insnReady          (insnReady),
        .insnValid          (insnValid),
        .insnPc             (insnPc),
        .insn               (insn),
        .insnCompressed     (insnCompressed),
        .insnFault          (insnFault),
        .insnInterruptValid (insnInterruptValid),
        .insnInterruptCode  (insnInterruptCode)
    );

endmodule

//--- design/InsnAligner.sv
// Instruction aligner, joins buffered halfwords into whole RV32IC instructions for decode
`timescale 1ns/1ps

module InsnAligner import rafiFetchPkg::*; (
    input  logic clk,
    input  logic arstN,
    AlignIF.InsnAligner align,
    input  logic insnReady,  // Decoder takes instruction
    output logic insnValid,
    output vaddr_t insnPc,
    output insn_t insn,
    output logic insnCompressed,
    output faultKind_e insnFault,
    output logic insnInterruptValid,
    output intCode_t insnInterruptCode
);
    ibufEntry_t head;
    ibufEntry_t next;
    logic headFault;
    logic isCompressed;  // Low bits not 2'b11
    logic needOne;  // Single parcel issue
    logic enough;  // Parcels present
    logic take;  // Handshake this cycle

    // ~~~~~~~~~~~~~~~~~~~~
    // Length decode
    // ~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        head = align.headEntry;
        next = align.nextEntry;
        headFault = head.fault != NONE;
        isCompressed = head.half[1:0] != 2'b11;
        needOne = isCompressed || headFault;  // Faulting parcel goes alone
        enough = needOne ? align.validCount >= 1 : align.validCount >= 2;
        take = enough && insnReady;
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Output assembly
    // ~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        insnValid = enough;
        insnPc = head.pc;
        insn = needOne ? {16'h0000, head.half} : {next.half, head.half};
        insnCompressed = isCompressed;
        // Second parcel may be the faulting one
        if (headFault) begin
            insnFault = head.fault;
        end else if (!needOne) begin
            insnFault = next.fault;
        end else begin
            insnFault = NONE;
        end
        insnInterruptValid = head.interruptValid;  // Tag of first parcel
        insnInterruptCode = head.interruptCode;
    end

    always_comb begin
        align.pop1 = take && needOne;
        align.pop2 = take && !needOne;
    end

    // Back-pressure holds the offer, only a flush may withdraw it
    property holdWhileNotReady;
        @(posedge clk) disable iff (!arstN)
        insnValid && !insnReady |=>
            !insnValid || ($stable(insn) && $stable(insnPc) && $stable(insnFault));
    endproperty
    assert property (holdWhileNotReady)
        else $error("Instruction changed while not ready");

endmodule

//--- fetch/FetchStage.sv
// Fetch stage, cuts the word at the PC into tagged halfwords for the instruction buffer
`timescale 1ns/1ps
`include "rafi_config.svh"

module FetchStage import rafiFetchPkg::*; (
    input  logic clk,
    input  logic arstN,
    FetchUnitIF.FetchStage fetchUnit,
    InsnBufferIF.FetchStage insnBuffer,
    input  logic redirect,  // External flush strobe
    input  vaddr_t redirectPc,
    input  logic ifStall,
    input  logic interruptValid,
    input  intCode_t interruptCode
);
    localparam int WORDS_IN_LINE = `RAFI_LINE_WIDTH / 32;
    localparam int INDEX_WIDTH = $clog2(WORDS_IN_LINE);

    function automatic ibufEntry_t makeEntry(input vaddr_t pc, input half_t half);
        ibufEntry_t entry;
        entry.pc = pc;
        entry.half = half;
        entry.fault = fetchUnit.fault;
        entry.interruptValid = interruptValid;  // Tag with pending interrupt
        entry.interruptCode = interruptCode;
        return entry;
    endfunction

    logic [INDEX_WIDTH-1:0] index;
    insn_t [WORDS_IN_LINE-1:0] words;
    insn_t word;
    logic halfAligned;  // PC bit 1 set
    logic stall;
    logic write;

    always_comb begin
        index = fetchUnit.pc[INDEX_WIDTH+1:2];
        words = fetchUnit.iLine;
        word = words[index];
        halfAligned = fetchUnit.pc[1];
        stall = ifStall || insnBuffer.writableEntryCount < 2;  // Room for both halves
        write = !stall && !redirect && fetchUnit.valid;  // Old path dropped on redirect
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Fetch unit control
    // ~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        fetchUnit.nextPc = redirectPc;
        fetchUnit.flush = redirect;
        fetchUnit.stall = stall;
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Buffer writes
    // ~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        insnBuffer.writeLow = write && !halfAligned;
        insnBuffer.writeHigh = write;
        insnBuffer.writeEntryLow = makeEntry(fetchUnit.pc, word[15:0]);
        // Upper parcel sits at PC itself when PC is halfword aligned
        insnBuffer.writeEntryHigh = makeEntry(halfAligned ? fetchUnit.pc
                                                          : fetchUnit.pc + 32'd2,
                                              word[31:16]);
    end

    // A stalled line is offered again at the same PC
    property holdPcOnStall;
        @(posedge clk) disable iff (!arstN)
        fetchUnit.valid && stall && !redirect |=> $stable(fetchUnit.pc);
    endproperty
    assert property (holdPcOnStall)
        else $error("Fetch PC moved during stall");

endmodule

//--- fetch/FetchUnit.sv
// Fetch unit, holds the PC and a loadable line memory and presents the line at the PC
`timescale 1ns/1ps
`include "rafi_config.svh"

module FetchUnit import rafiFetchPkg::*; (
    input  logic clk,
    input  logic arstN,
    input  logic memWe,  // Load strobe, idle only
    input  logic [3:0] memLineIdx,
    input  line_t memLine,
    FetchUnitIF.FetchUnit fetchUnit
);
    localparam int LINE_BYTES = `RAFI_LINE_WIDTH / 8;
    localparam int OFFSET_WIDTH = $clog2(LINE_BYTES);  // Byte bits in line
    localparam int INDEX_WIDTH = $clog2(`RAFI_IMEM_LINES);  // Line select bits
    localparam vaddr_t MEM_LIMIT = vaddr_t'(`RAFI_IMEM_LINES * LINE_BYTES);

    line_t mem [`RAFI_IMEM_LINES];  // Instruction store
    vaddr_t pc;
    logic valid;
    logic outOfRange;
    logic accept;  // Line taken by stage
    vaddr_t seqPc;  // Sequential successor
    logic [INDEX_WIDTH-1:0] lineIdx;

    // ~~~~~~~~~~~~~~~~~~~~
    // Memory
    // ~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (memWe) begin
            mem[memLineIdx] <= memLine;  // Loaded from top
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Next PC
    // ~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        lineIdx = pc[INDEX_WIDTH+OFFSET_WIDTH-1:OFFSET_WIDTH];
        outOfRange = pc >= MEM_LIMIT;
        accept = valid && !fetchUnit.stall;
        // Halfword PC only supplies its upper parcel
        seqPc = pc[1] ? pc + 32'd2 : pc + 32'd4;
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc <= '0;
            valid <= 1'b0;
        end else if (fetchUnit.flush) begin
            pc <= fetchUnit.nextPc;  // Redirect wins over stall
            valid <= 1'b1;
        end else if (accept) begin
            pc <= seqPc;
            valid <= !outOfRange;  // Go idle after a faulting line
        end
    end

    always_comb begin
        fetchUnit.pc = pc;
        fetchUnit.iLine = mem[lineIdx];  // Garbage when out of range
        fetchUnit.valid = valid;
        fetchUnit.fault = outOfRange ? OUT_OF_RANGE : NONE;
    end

    // Program load must not race a running fetch
    property noLoadWhileFetching;
        @(posedge clk) disable iff (!arstN)
        !(memWe && fetchUnit.valid);
    endproperty
    assert property (noLoadWhileFetching)
        else $error("Memory written while fetch active");

endmodule

//--- fetch/InsnBuffer.sv
// Halfword instruction buffer, a circular queue with two writes and up to two pops per cycle
`timescale 1ns/1ps
`include "rafi_config.svh"

module InsnBuffer import rafiFetchPkg::*; (
    input  logic clk,
    input  logic arstN,
    input  logic flush,  // Empties queue this edge
    InsnBufferIF.InsnBuffer insnBuffer,
    AlignIF.InsnBuffer align
);
    localparam int DEPTH = `RAFI_IBUF_DEPTH;
    localparam int PTR_WIDTH = $clog2(DEPTH);

    typedef logic [PTR_WIDTH-1:0] ptr_t;

    ibufEntry_t entries [DEPTH];  // Payload store
    ptr_t rdPtr;  // Oldest entry
    ptr_t wrPtr;  // Next free slot
    ibufCount_t count;  // Occupied slots
    ptr_t highPtr;  // Slot for high half
    ptr_t rdPtrNext;  // Second oldest
    logic [1:0] writeNum;
    logic [1:0] popNum;

    // ~~~~~~~~~~~~~~~~~~~~
    // Pointer math
    // ~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        writeNum = {1'b0, insnBuffer.writeLow} + {1'b0, insnBuffer.writeHigh};
        popNum = align.pop2 ? 2'd2 : (align.pop1 ? 2'd1 : 2'd0);
        // High half follows low half in queue order
        highPtr = insnBuffer.writeLow ? wrPtr + ptr_t'(1) : wrPtr;
        rdPtrNext = rdPtr + ptr_t'(1);  // Wraps with power of two depth
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Storage
    // ~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (!flush) begin
            if (insnBuffer.writeLow) begin
                entries[wrPtr] <= insnBuffer.writeEntryLow;
            end
            if (insnBuffer.writeHigh) begin
                entries[highPtr] <= insnBuffer.writeEntryHigh;
            end
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            rdPtr <= '0;
            wrPtr <= '0;
            count <= '0;
        end else if (flush) begin
            rdPtr <= '0;  // Drop everything, writes too
            wrPtr <= '0;
            count <= '0;
        end else begin
            wrPtr <= wrPtr + ptr_t'(writeNum);
            rdPtr <= rdPtr + ptr_t'(popNum);
            count <= count + ibufCount_t'(writeNum) - ibufCount_t'(popNum);
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Status and head
    // ~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        insnBuffer.writableEntryCount = ibufCount_t'(DEPTH) - count;
        align.headEntry = entries[rdPtr];
        align.nextEntry = entries[rdPtrNext];  // Only meaningful when count >= 2
        align.validCount = count;
    end

    // Aligner must not take parcels that are not there
    property noPopUnderflow;
        @(posedge clk) disable iff (!arstN)
        ibufCount_t'(popNum) <= count;
    endproperty
    assert property (noPopUnderflow)
        else $error("Pop beyond valid entries");

    // Stage stall has to keep writes within free space
    property noWriteOverflow;
        @(posedge clk) disable iff (!arstN)
        ibufCount_t'(writeNum) <= insnBuffer.writableEntryCount;
    endproperty
    assert property (noWriteOverflow)
        else $error("Write beyond free space");

endmodule

//--- tb/frontEndTests.svh
// Directed front end tests, included inside the testbench module and sharing its signals

// ~~~~~~~~~~~~~~~~~~~~
// Stimulus helpers
// ~~~~~~~~~~~~~~~~~~~~

task automatic loadProgram(input logic [7:0] salt);
    int i;
    int b;
    line_t lineData;
    buildProgram(salt);  // Model copy first
    for (i = 0; i < `RAFI_IMEM_LINES; i++) begin
        for (b = 0; b < 8; b++) begin
            lineData[8*b +: 8] = progByte[8*i + b];
        end
        @(posedge clk);
        memWe <= 1'b1;
        memLineIdx <= 4'(i);
        memLine <= lineData;
    end
    @(posedge clk);
    memWe <= 1'b0;
endtask

task automatic redirectTo(input vaddr_t target);
    @(posedge clk);
    redirect <= 1'b1;
    redirectPc <= target;
    @(posedge clk);
    redirect <= 1'b0;  // One cycle strobe
endtask

// Sends fetch past memory so it goes idle before the next load
task automatic parkFetch();
    @(posedge clk);
    insnReady <= 1'b1;  // Drain faulting parcels
    redirectTo(vaddr_t'(MEM_BYTES));
    repeat (4) @(posedge clk);
endtask

// Checks count accepted instructions from startPc, ready driven high or random
task automatic runStream(input vaddr_t startPc, input int count, input logic randomReady);
    vaddr_t expPc;
    int accepted;
    logic held;
    vaddr_t heldPc;
    insn_t heldInsn;
    expPc = startPc;
    accepted = 0;
    held = 1'b0;
    while (accepted < count) begin
        @(posedge clk);
        insnReady <= randomReady ? (($random(seed) & 3) != 0) : 1'b1;
        @(negedge clk);  // Mid cycle, outputs settled
        if (held) begin
            assert (insnValid && insnPc === heldPc && insn === heldInsn) else begin
                otherCount++;
                $display("At %0t the offered instruction changed while insnReady was low",
                         $time);
            end
        end
        held = insnValid && !insnReady;
        heldPc = insnPc;
        heldInsn = insn;
        if (insnValid && insnReady) begin  // Taken at next edge
            checkInsn(expPc);
            expPc = expPc + (wideAt(expPc) ? 32'd4 : 32'd2);
            accepted++;
        end
    end
endtask

// ~~~~~~~~~~~~~~~~~~~~
// Tests
// ~~~~~~~~~~~~~~~~~~~~

task automatic testMixedStream();
    loadProgram(8'h11);
    redirectTo(32'd0);
    runStream(32'd0, MIXED_COUNT, 1'b0);  // Includes 32-bit at PC 6
    parkFetch();
endtask

task automatic testHalfwordRedirect();
    loadProgram(8'h22);
    redirectTo(32'd38);  // Misaligned 32-bit start
    runStream(32'd38, HALF_COUNT, 1'b0);
    parkFetch();
endtask

task automatic testReadyStalls();
    loadProgram(8'h33);
    redirectTo(32'd0);
    runStream(32'd0, READY_COUNT, 1'b1);  // Whole memory under back-pressure
    parkFetch();
endtask

task automatic testMidStreamRedirect();
    loadProgram(8'h44);
    redirectTo(32'd0);
    runStream(32'd0, SWITCH_BEFORE, 1'b0);
    redirectTo(32'd70);  // Old parcels must vanish
    runStream(32'd70, SWITCH_AFTER, 1'b0);
    parkFetch();
endtask

task automatic testPastMemoryEnd();
    loadProgram(8'h55);
    redirectTo(32'd112);
    runStream(32'd112, EDGE_COUNT, 1'b0);  // Last one at PC 128
    parkFetch();
endtask

task automatic testInterruptTag();
    loadProgram(8'h66);
    @(posedge clk);
    interruptValid <= 1'b1;  // Held through the whole fetch
    interruptCode <= 4'hB;
    expIntValid = 1'b1;
    expIntCode = 4'hB;
    redirectTo(32'd16);
    runStream(32'd16, IRQ_COUNT, 1'b0);
    parkFetch();
    @(posedge clk);
    interruptValid <= 1'b0;
    expIntValid = 1'b0;
    expIntCode = '0;
endtask

//--- tb/tbFrontEnd.sv
// Testbench for the front end, runs directed tests against a software aligner model
`timescale 1ns/1ps
`include "rafi_config.svh"

module tbFrontEnd import rafiFetchPkg::*; ();
    localparam int MEM_BYTES = `RAFI_IMEM_LINES * 8;
    localparam int MIXED_COUNT = 12;  // Accepted instructions per test
    localparam int HALF_COUNT = 10;
    localparam int READY_COUNT = 40;
    localparam int SWITCH_BEFORE = 6;  // Old path part
    localparam int SWITCH_AFTER = 8;  // New path part
    localparam int EDGE_COUNT = 6;  // Ends on the faulting one
    localparam int IRQ_COUNT = 8;
    localparam int TIMEOUT_CYCLES = (MIXED_COUNT + HALF_COUNT + READY_COUNT + SWITCH_BEFORE
                                     + SWITCH_AFTER + EDGE_COUNT + IRQ_COUNT) * 8 + 200;

    logic clk;
    logic arstN;
    logic memWe;
    logic [3:0] memLineIdx;
    line_t memLine;
    logic redirect;
    vaddr_t redirectPc;
    logic ifStall;
    logic interruptValid;
    intCode_t interruptCode;
    logic insnReady;
    logic insnValid;
    vaddr_t insnPc;
    insn_t insn;
    logic insnCompressed;
    faultKind_e insnFault;
    logic insnInterruptValid;
    intCode_t insnInterruptCode;

    logic [7:0] progByte [MEM_BYTES];  // Model copy of memory
    logic expIntValid;  // Tag the model expects
    intCode_t expIntCode;
    int checkCount = 0;
    int mismatchCount = 0;
    int otherCount = 0;  // Hold and timeout failures
    int cycleCount = 0;
    integer seed;

    FrontEnd u_FrontEnd (
        .clk                (clk),
        .arstN              (arstN),
        .memWe              (memWe),
        .memLineIdx         (memLineIdx),
        .memLine            (memLine),
        .redirect           (redirect),
        .redirectPc         (redirectPc),
        .ifStall            (ifStall),
        .interruptValid     (interruptValid),
        .interruptCode      (interruptCode),
        .insnReady          (insnReady),
        .insnValid          (insnValid),
        .insnPc             (insnPc),
        .insn               (insn),
        .insnCompressed     (insnCompressed),
        .insnFault          (insnFault),
        .insnInterruptValid (insnInterruptValid),
        .insnInterruptCode  (insnInterruptCode)
    );

    // ~~~~~~~~~~~~~~~~~~~~
    // Reference model
    // ~~~~~~~~~~~~~~~~~~~~

    // Five instruction group of 32,16,32,16,32 bits, 16 bytes, so the end lands on 128
    function automatic void buildProgram(input logic [7:0] salt);
        int addr;
        int k;
        int len;
        int b;
        logic [31:0] word;
        addr = 0;
        k = 0;
        while (addr < MEM_BYTES) begin
            if (k % 5 == 1 || k % 5 == 3 || addr + 4 > MEM_BYTES) begin
                word = {16'h0000, 8'(addr) ^ salt, 6'(k), 2'(k % 3)};  // Low bits never 11
                len = 2;
            end else begin
                word = {salt, 8'(addr), 8'(k), 6'(addr >> 1), 2'b11};
                len = 4;
            end
            for (b = 0; b < len; b++) begin
                progByte[addr + b] = word[8*b +: 8];  // Little endian
            end
            addr += len;
            k++;
        end
    endfunction

    function automatic half_t halfAt(input int addr);
        return {progByte[addr + 1], progByte[addr]};
    endfunction

    // Full width instruction at pc
    function automatic logic wideAt(input vaddr_t pc);
        half_t lo;
        if (pc >= MEM_BYTES) begin
            return 1'b0;  // Faulting parcel goes alone
        end
        lo = halfAt(pc);
        return lo[1:0] == 2'b11;
    endfunction

    task automatic compareField(input string name, input logic [31:0] got,
                                input logic [31:0] expected);
        checkCount++;
        assert (got === expected) else begin
            mismatchCount++;
            $display("mismatch at %0t: %s is %h, expected %h", $time, name, got, expected);
        end
    endtask

    task automatic checkInsn(input vaddr_t pc);
        half_t lo;
        half_t hi;
        logic wide;
        faultKind_e fault;
        lo = '0;
        hi = '0;
        wide = wideAt(pc);
        if (pc < MEM_BYTES) begin
            lo = halfAt(pc);
        end
        if (wide && pc + 2 < MEM_BYTES) begin
            hi = halfAt(pc + 2);
        end
        // Either parcel outside memory
        fault = (pc >= MEM_BYTES || (wide && pc + 2 >= MEM_BYTES)) ? OUT_OF_RANGE : NONE;
        compareField("insnPc", insnPc, pc);
        compareField("insnFault", insnFault, fault);
        if (fault == NONE) begin  // Word is don't care past memory
            compareField("insn", insn, wide ? {hi, lo} : {16'h0000, lo});
            compareField("insnCompressed", insnCompressed, !wide);
        end
        compareField("insnInterruptValid", insnInterruptValid, expIntValid);
        compareField("insnInterruptCode", insnInterruptCode, expIntCode);
    endtask

    function automatic void reportCounts();
        $display("Checks %0d, mismatches %0d, other errors %0d",
                 checkCount, mismatchCount, otherCount);
    endfunction

`include "frontEndTests.svh"

    // ~~~~~~~~~~~~~~~~~~~~
    // Clock, run, watchdog
    // ~~~~~~~~~~~~~~~~~~~~

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;  // 20 ns period
    end

    initial begin
        seed = 28972;
        arstN = 1'b0;
        memWe = 1'b0;
        memLineIdx = '0;
        memLine = '0;
        redirect = 1'b0;
        redirectPc = '0;
        ifStall = 1'b0;
        interruptValid = 1'b0;
        interruptCode = '0;
        insnReady = 1'b0;
        expIntValid = 1'b0;
        expIntCode = '0;
        repeat (8) @(posedge clk);
        arstN <= 1'b1;
        testMixedStream();
        testHalfwordRedirect();
        testReadyStalls();
        testMidStreamRedirect();
        testPastMemoryEnd();
        testInterruptTag();
        reportCounts();
        if (mismatchCount == 0 && otherCount == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin
        while (cycleCount < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycleCount++;
        end
        otherCount++;
        $display("Timeout, the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        reportCounts();
        $display("Done: errors found");
        $finish;
    end

endmodule
